//--- mips_sys.f
+incdir+rtl
rtl/mips_isa_pkg.sv
rtl/mips_host_pkg.sv
rtl/mips_if.sv
rtl/mips_control.sv
rtl/mips_alu.sv
rtl/mips_datapath.sv
rtl/mips_ram.sv
rtl/mips_host_regs.sv
rtl/mips_sys.sv
dv/mips_sys_asserts.sv
dv/mips_sys_tb.sv

//--- Makefile
# Verilator build and run for the mips_sys testbench

VERILATOR ?= verilator
TOP       ?= mips_sys_tb
FLIST     ?= mips_sys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --x-initial 0 -Wno-fatal -j 0

SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/mips_sys_tb.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips_sys_tb;

	// apb word offsets
	localparam logic [7:0] adr_steps = 8'h00;
	localparam logic [7:0] adr_status = 8'h04;
	localparam logic [7:0] adr_pc = 8'h08;
	localparam logic [7:0] adr_imem_addr = 8'h0c;
	localparam logic [7:0] adr_imem_data = 8'h10;
	localparam logic [7:0] adr_dmem_addr = 8'h14;
	localparam logic [7:0] adr_dmem_data = 8'h18;

	// standard mips encodings
	localparam logic [5:0] opc_r = 6'h00;
	localparam logic [5:0] opc_j = 6'h02;
	localparam logic [5:0] opc_beq = 6'h04;
	localparam logic [5:0] opc_addi = 6'h08;
	localparam logic [5:0] opc_lw = 6'h23;
	localparam logic [5:0] opc_sw = 6'h2b;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;
	localparam int poll_limit = 200; // status reads per run

	logic clk;
	logic rst_n;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`MIPS_DW-1:0] pwdata;
	logic [`MIPS_DW-1:0] prdata;
	logic pready;
	logic pslverr;

	// reference model state
	logic [31:0] m_imem [`MIPS_IMEM_WORDS];
	logic [31:0] m_dmem [`MIPS_DMEM_WORDS]; // survives reset like the ram
	logic [31:0] m_rf [32];
	logic [31:0] m_pc;
	logic [31:0] prog [$]; // program under construction
	string test_name;
	int n_tests, n_checks, n_errors;
	int test_checks, test_errs;

	mips_sys mips_sys_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	bind mips_host_regs mips_sys_asserts asserts_u (
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pready     (pready),
		.busy       (busy),
		.step_en    (step_en),
		.steps_load (steps_load),
		.pwdata     (pwdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns
	end

	//////////////////////////////////////////////////
	// instruction encoders

	function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {opc_r, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [25:0] tgt);
		return {opc_j, tgt}; // word index
	endfunction

	//////////////////////////////////////////////////
	// isa reference model, runs n instructions from m_pc

	function automatic void mips_model(input int n);
		logic [31:0] instr, a, b, simm, nxt, res;
		logic [5:0] op, fn;
		logic [4:0] rs, rt, rd;
		logic wr;
		for (int k = 0; k < n; k++) begin
			instr = m_imem[(m_pc >> 2) % `MIPS_IMEM_WORDS];
			op = instr[31:26];
			fn = instr[5:0];
			rs = instr[25:21];
			rt = instr[20:16];
			rd = instr[15:11];
			a = m_rf[rs];
			b = m_rf[rt];
			simm = {{16{instr[15]}}, instr[15:0]};
			nxt = m_pc + 32'd4;
			wr = 1'b1;
			res = '0;
			case (op)
				opc_r: begin
					case (fn)
						fn_add: res = a + b;
						fn_sub: res = a - b;
						fn_and: res = a & b;
						fn_or: res = a | b;
						fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0; // unsupported funct writes nothing
					endcase
					if (wr && rd != 5'd0)
						m_rf[rd] = res;
				end
				opc_addi: if (rt != 5'd0) m_rf[rt] = a + simm;
				opc_lw: if (rt != 5'd0) m_rf[rt] = m_dmem[((a + simm) >> 2) % `MIPS_DMEM_WORDS];
				opc_sw: m_dmem[((a + simm) >> 2) % `MIPS_DMEM_WORDS] = b;
				opc_beq: if (a == b) nxt = m_pc + 32'd4 + (simm << 2);
				opc_j: nxt = {m_pc[31:28], instr[25:0], 2'b00};
				default: ; // no-op
			endcase
			m_pc = nxt;
		end
	endfunction

	//////////////////////////////////////////////////
	// checks and bookkeeping

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		test_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errs++;
			$display("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errs = 0;
	endtask

	task automatic end_test();
		n_tests++;
		$display("test %s finished, %0d checks, %0d failed", test_name, test_checks, test_errs);
	endtask

	//////////////////////////////////////////////////
	// apb access, setup then access, sampled mid access

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		input logic exp_err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_val($sformatf("pready on write %h", addr), 32'h1, {31'd0, pready});
		check_val($sformatf("pslverr on write %h", addr), {31'd0, exp_err}, {31'd0, pslverr});
		@(posedge clk); // transfer completes here
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic exp_err,
		output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		check_val($sformatf("pready on read %h", addr), 32'h1, {31'd0, pready});
		check_val($sformatf("pslverr on read %h", addr), {31'd0, exp_err}, {31'd0, pslverr});
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// host level helpers

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		m_pc = '0; // dmem is not reset, model keeps it
		foreach (m_rf[i])
			m_rf[i] = '0;
	endtask

	task automatic load_program();
		apb_write(adr_imem_addr, 32'h0, 1'b0);
		foreach (prog[i]) begin
			apb_write(adr_imem_data, prog[i], 1'b0); // address auto increments
			m_imem[i] = prog[i];
		end
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		int polls;
		st = 32'h1;
		polls = 0;
		while (st[0] && polls < poll_limit) begin
			apb_read(adr_status, 1'b0, st);
			polls++;
		end
		if (st[0]) begin
			$display("timeout: core still busy after %0d status reads", polls);
			$display("ERRORS FOUND");
			$finish;
		end
	endtask

	task automatic run_steps(input int n);
		apb_write(adr_steps, n, 1'b0);
		wait_idle();
		mips_model(n);
	endtask

	task automatic check_pc();
		logic [31:0] d;
		apb_read(adr_pc, 1'b0, d);
		check_val("pc", m_pc, d);
	endtask

	task automatic compare_dmem(input logic [31:0] base, input int count);
		logic [31:0] d, addr;
		for (int i = 0; i < count; i++) begin
			addr = base + 32'(4 * i);
			apb_write(adr_dmem_addr, addr, 1'b0);
			apb_read(adr_dmem_data, 1'b0, d);
			check_val($sformatf("dmem[%h]", addr), m_dmem[(addr >> 2) % `MIPS_DMEM_WORDS], d);
		end
	endtask

	// counter loop, stores the count at slot every pass
	task automatic build_loop(input logic [15:0] slot);
		prog.delete();
		prog.push_back(enc_i(opc_addi, 0, 1, 16'h0000));
		prog.push_back(enc_i(opc_addi, 1, 1, 16'h0001));
		prog.push_back(enc_i(opc_sw, 0, 1, slot));
		prog.push_back(enc_j(26'd1)); // back to the increment
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial begin
		logic [31:0] d;
		logic [15:0] imm_a, imm_b;
		int n;
		void'($urandom(51));
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		n_tests = 0;
		n_checks = 0;
		n_errors = 0;
		foreach (m_imem[i])
			m_imem[i] = '0;
		foreach (m_dmem[i])
			m_dmem[i] = '0;
		apply_reset();

		start_test("reset");
		apb_read(adr_status, 1'b0, d);
		check_val("status", 32'h0, d);
		check_pc();
		compare_dmem(32'h0, 4);
		compare_dmem(32'h3f0, 4); // top of dmem
		end_test();

		start_test("arith");
		for (int it = 0; it < 3; it++) begin
			imm_a = 16'($urandom);
			imm_b = 16'($urandom);
			apply_reset();
			prog.delete();
			prog.push_back(enc_i(opc_addi, 0, 1, imm_a));
			prog.push_back(enc_i(opc_addi, 0, 2, imm_b));
			prog.push_back(enc_r(fn_add, 1, 2, 3));
			prog.push_back(enc_r(fn_sub, 1, 2, 4));
			prog.push_back(enc_r(fn_and, 1, 2, 5));
			prog.push_back(enc_r(fn_or, 1, 2, 6));
			prog.push_back(enc_r(fn_slt, 1, 2, 7));
			for (int k = 1; k <= 7; k++)
				prog.push_back(enc_i(opc_sw, 0, 5'(k), 16'h20 + 16'(4 * k)));
			load_program();
			run_steps(14);
			check_pc();
			compare_dmem(32'h24, 7);
		end
		end_test();

		start_test("mem_branch");
		apply_reset();
		prog.delete();
		prog.push_back(enc_i(opc_addi, 0, 1, 16'h0055));
		prog.push_back(enc_i(opc_sw, 0, 1, 16'h0080));
		prog.push_back(enc_i(opc_lw, 0, 2, 16'h0080)); // load back what was stored
		prog.push_back(enc_i(opc_beq, 1, 2, 16'h0001)); // taken
		prog.push_back(enc_i(opc_addi, 0, 3, 16'h0001)); // skipped
		prog.push_back(enc_i(opc_addi, 0, 4, 16'h0007));
		prog.push_back(enc_i(opc_beq, 1, 4, 16'h0001)); // not taken
		prog.push_back(enc_i(opc_addi, 0, 5, 16'h0009));
		prog.push_back(enc_i(opc_sw, 0, 2, 16'h0084));
		prog.push_back(enc_i(opc_sw, 0, 3, 16'h0088));
		prog.push_back(enc_i(opc_sw, 0, 5, 16'h008c));
		prog.push_back(enc_i(opc_sw, 0, 4, 16'h0090));
		load_program();
		run_steps(11);
		check_pc();
		compare_dmem(32'h80, 5);
		end_test();

		start_test("jump_steps");
		apply_reset();
		build_loop(16'h00c0);
		load_program();
		for (int r = 0; r < 6; r++) begin
			n = 1 + ($urandom % 40);
			run_steps(n); // continues from the previous pc
			check_pc();
			compare_dmem(32'hc0, 1);
		end
		end_test();

		start_test("busy_protect");
		apply_reset();
		build_loop(16'h0100);
		load_program();
		apb_write(adr_imem_addr, 32'h4, 1'b0); // a leaked write would hit the increment
		apb_write(adr_steps, 32'd200, 1'b0);
		apb_read(adr_status, 1'b0, d);
		check_val("status while running", 32'h1, d);
		apb_write(adr_steps, 32'd5, 1'b1);
		apb_write(adr_imem_data, 32'h0, 1'b1);
		apb_read(adr_dmem_data, 1'b1, d);
		apb_write(8'h40, 32'h1, 1'b1); // unmapped
		wait_idle();
		mips_model(200);
		check_pc();
		compare_dmem(32'h100, 1);
		apb_read(adr_imem_addr, 1'b0, d);
		check_val("imem_addr", 32'h4, d);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- dv/mips_sys_asserts.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

// bound into mips_host_regs
module mips_sys_asserts (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic busy,
	input logic step_en,
	input logic steps_load, // accepted steps write, nonzero
	input logic [`MIPS_DW-1:0] pwdata
);

	logic [`MIPS_STEP_W-1:0] left; // steps still due

	// shadow count, loaded by the same write that starts the run
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			left <= '0;
		else if (steps_load)
			left <= pwdata[`MIPS_STEP_W-1:0];
		else if (left != '0)
			left <= left - 1'b1;
	end

	//////////////////////////////////////////////////
	// apb and run behavior

	a_pready: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable) |-> pready)
		else $error("pready low in access phase");

	// busy high exactly while steps remain, so it drops N clocks after the write
	a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
		busy == (left != '0))
		else $error("busy does not match the requested step count");

	// no step once the requested count is used up
	a_step_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(left == '0) |-> !step_en)
		else $error("step_en high while not busy");

endmodule

//--- rtl/mips_sys.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips_sys (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`MIPS_DW-1:0] pwdata,
	output logic [`MIPS_DW-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic [`MIPS_DW-1:0] pc;
	logic step_en;

	core_ctrl_if ctrl_i ();
	mem_port_if imem_core_i (); // fetch
	mem_port_if dmem_core_i (); // lw sw
	mem_port_if imem_host_i (); // program load
	mem_port_if dmem_host_i (); // result readback

	//////////////////////////////////////////////////
	// host side

	mips_host_regs host_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.pc        (pc),
		.step_en   (step_en),
		.imem_host (imem_host_i.initiator),
		.dmem_host (dmem_host_i.initiator)
	);

	//////////////////////////////////////////////////
	// core

	mips_control ctrl_u (.ctrl(ctrl_i.control));

	mips_datapath dp_u (
		.clk     (clk),
		.rst_n   (rst_n),
		.step_en (step_en),
		.ctrl    (ctrl_i.datapath),
		.imem    (imem_core_i.initiator),
		.dmem    (dmem_core_i.initiator),
		.pc      (pc)
	);

	// port a core, port b host
	mips_ram #(.WORDS(`MIPS_IMEM_WORDS)) imem_u (
		.clk (clk),
		.a   (imem_core_i.target),
		.b   (imem_host_i.target)
	);

	mips_ram #(.WORDS(`MIPS_DMEM_WORDS)) dmem_u (
		.clk (clk),
		.a   (dmem_core_i.target),
		.b   (dmem_host_i.target)
	);

endmodule

//--- rtl/mips_host_regs.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips_host_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`MIPS_DW-1:0] pwdata,
	output logic [`MIPS_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic [`MIPS_DW-1:0] pc,
	output logic step_en,
	mem_port_if.initiator imem_host,
	mem_port_if.initiator dmem_host
);

	mips_host_pkg::run_state_e state;
	mips_host_pkg::reg_addr_e reg_sel;
	logic [`MIPS_STEP_W-1:0] step_cnt; // instrs left
	logic [`MIPS_DW-1:0] imem_addr, dmem_addr;
	logic busy, mapped;
	logic wr_acc, rd_acc; // apb access phase
	logic wr_err, rd_err, wr_ok;
	logic steps_load;

	//////////////////////////////////////////////////
	// apb decode

	assign reg_sel = mips_host_pkg::reg_addr_e'(paddr);

	always_comb begin
		case (reg_sel)
			mips_host_pkg::reg_steps, mips_host_pkg::reg_status, mips_host_pkg::reg_pc,
			mips_host_pkg::reg_imem_addr, mips_host_pkg::reg_imem_data,
			mips_host_pkg::reg_dmem_addr, mips_host_pkg::reg_dmem_data: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	assign wr_acc = psel & penable & pwrite;
	assign rd_acc = psel & penable & ~pwrite;
	assign busy = (state == mips_host_pkg::running);

	// busy rules
	assign wr_err = busy & (~mapped | reg_sel == mips_host_pkg::reg_steps |
		reg_sel == mips_host_pkg::reg_imem_data);
	assign rd_err = busy & (reg_sel == mips_host_pkg::reg_dmem_data);
	assign wr_ok = wr_acc & ~wr_err;

	assign pready = 1'b1; // zero wait states
	assign pslverr = (wr_acc & wr_err) | (rd_acc & rd_err);

	assign steps_load = wr_ok & (reg_sel == mips_host_pkg::reg_steps) &
		(pwdata[`MIPS_STEP_W-1:0] != '0); // 0 steps ignored

	//////////////////////////////////////////////////
	// address regs and memory ports

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			imem_addr <= '0;
			dmem_addr <= '0;
		end else if (wr_ok) begin
			case (reg_sel)
				mips_host_pkg::reg_imem_addr: imem_addr <= pwdata;
				mips_host_pkg::reg_imem_data: imem_addr <= imem_addr + `MIPS_DW'd4; // next word
				mips_host_pkg::reg_dmem_addr: dmem_addr <= pwdata;
				default: ;
			endcase
		end
	end

	assign imem_host.addr = imem_addr;
	assign imem_host.wdata = pwdata;
	assign imem_host.we = wr_ok & (reg_sel == mips_host_pkg::reg_imem_data);
	assign dmem_host.addr = dmem_addr;
	assign dmem_host.wdata = '0;
	assign dmem_host.we = 1'b0; // dmem is read only for host

	//////////////////////////////////////////////////
	// run fsm

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mips_host_pkg::idle;
			step_cnt <= '0;
		end else begin
			case (state)
				mips_host_pkg::idle: if (steps_load) begin
					step_cnt <= pwdata[`MIPS_STEP_W-1:0];
					state <= mips_host_pkg::running;
				end
				mips_host_pkg::running: begin
					step_cnt <= step_cnt - 1'b1;
					if (step_cnt == `MIPS_STEP_W'd1)
						state <= mips_host_pkg::idle; // last instr this clock
				end
				default: state <= mips_host_pkg::idle;
			endcase
		end
	end

	assign step_en = busy; // one instr per running clock

	// read mux, write-only regs read 0
	always_comb begin
		case (reg_sel)
			mips_host_pkg::reg_status: prdata = {{(`MIPS_DW-1){1'b0}}, busy};
			mips_host_pkg::reg_pc: prdata = pc;
			mips_host_pkg::reg_imem_addr: prdata = imem_addr;
			mips_host_pkg::reg_dmem_addr: prdata = dmem_addr;
			mips_host_pkg::reg_dmem_data: prdata = busy ? '0 : dmem_host.rdata;
			default: prdata = '0;
		endcase
	end

endmodule

//--- rtl/mips_ram.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips_ram #(
	parameter int WORDS = `MIPS_DMEM_WORDS
) (
	input  logic clk,
	mem_port_if.target a, // core side
	mem_port_if.target b  // host side
);

	localparam int AW = $clog2(WORDS);

	logic [`MIPS_DW-1:0] mem [WORDS];
	logic [AW-1:0] a_idx, b_idx;

	// byte address to word index, wraps at depth
	assign a_idx = AW'((a.addr >> 2) % WORDS);
	assign b_idx = AW'((b.addr >> 2) % WORDS);

	// comb read on both ports
	assign a.rdata = mem[a_idx];
	assign b.rdata = mem[b_idx];

	always_ff @(posedge clk) begin
		if (a.we)
			mem[a_idx] <= a.wdata;
		if (b.we)
			mem[b_idx] <= b.wdata; // b wins on same word
	end

endmodule

//--- rtl/mips_datapath.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips_datapath (
	input  logic clk,
	input  logic rst_n,
	input  logic step_en, // from host block, else hold
	core_ctrl_if.datapath ctrl,
	mem_port_if.initiator imem,
	mem_port_if.initiator dmem,
	output logic [`MIPS_DW-1:0] pc
);

	logic [`MIPS_DW-1:0] instr;
	logic [4:0] rs, rt, rd, wr_reg;
	logic [`MIPS_DW-1:0] rf [32]; // r0 never written
	logic [`MIPS_DW-1:0] rd1, rd2;
	logic [`MIPS_DW-1:0] sign_imm, src_b, alu_y, wb_data;
	logic [`MIPS_DW-1:0] pc_plus4, pc_branch, pc_jump, pc_next;
	logic zero;
	logic pc_src; // branch taken

	//////////////////////////////////////////////////
	// fetch and field split

	assign imem.addr = pc;
	assign imem.wdata = '0;
	assign imem.we = 1'b0; // core only reads imem
	assign instr = imem.rdata;

	assign ctrl.opcode = mips_isa_pkg::opcode_e'(instr[31:26]);
	assign ctrl.funct = mips_isa_pkg::funct_e'(instr[5:0]);
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	//////////////////////////////////////////////////
	// pc and next pc

	assign pc_plus4 = pc + `MIPS_DW'd4;
	assign sign_imm = {{(`MIPS_DW-16){instr[15]}}, instr[15:0]};
	assign pc_branch = pc_plus4 + {sign_imm[`MIPS_DW-3:0], 2'b00}; // imm << 2
	assign pc_jump = {pc[`MIPS_DW-1:28], instr[25:0], 2'b00}; // top 4 bits kept
	assign pc_src = ctrl.branch & zero;

	always_comb begin
		if (ctrl.jump)
			pc_next = pc_jump;
		else if (pc_src)
			pc_next = pc_branch;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (step_en)
			pc <= pc_next; // one instr per clock
	end

	//////////////////////////////////////////////////
	// register file

	assign wr_reg = ctrl.reg_dst ? rd : rt;
	assign rd1 = rf[rs]; // comb read
	assign rd2 = rf[rt];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				rf[i] <= '0;
			end
		end else if (step_en && ctrl.reg_write && wr_reg != 5'd0) begin
			rf[wr_reg] <= wb_data;
		end
	end

	//////////////////////////////////////////////////
	// alu, dmem, write-back

	assign src_b = ctrl.alu_src ? sign_imm : rd2;

	mips_alu alu_u (
		.a    (rd1),
		.b    (src_b),
		.op   (ctrl.alu_op),
		.y    (alu_y),
		.zero (zero)
	);

	assign dmem.addr = alu_y; // effective address
	assign dmem.wdata = rd2; // sw stores rt
	assign dmem.we = ctrl.mem_write & step_en;

	assign wb_data = ctrl.mem_to_reg ? dmem.rdata : alu_y;

endmodule

//--- rtl/mips_alu.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

module mips_alu (
	input  logic [`MIPS_DW-1:0] a,
	input  logic [`MIPS_DW-1:0] b,
	input  mips_isa_pkg::alu_op_e op,
	output logic [`MIPS_DW-1:0] y,
	output logic zero
);

	logic lt; // signed a < b

	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mips_isa_pkg::alu_and: y = a & b;
			mips_isa_pkg::alu_or: y = a | b;
			mips_isa_pkg::alu_add: y = a + b; // no overflow trap
			mips_isa_pkg::alu_sub: y = a - b;
			mips_isa_pkg::alu_slt: y = {{(`MIPS_DW-1){1'b0}}, lt};
			default: y = '0;
		endcase
	end

	// beq takes this after a sub
	assign zero = (y == '0);

endmodule

//--- rtl/mips_control.sv
`timescale 1ns/10ps

module mips_control (
	core_ctrl_if.control ctrl
);

	logic [1:0] alu_mode; // 00 add, 01 sub, 1x by funct
	logic funct_ok; // funct is one we support

	//////////////////////////////////////////////////
	// main decoder

	always_comb begin
		// defaults give a no-op
		ctrl.reg_write = 1'b0;
		ctrl.reg_dst = 1'b0;
		ctrl.alu_src = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.mem_to_reg = 1'b0;
		ctrl.jump = 1'b0;
		alu_mode = 2'b00;
		case (ctrl.opcode)
			mips_isa_pkg::r_type: begin
				ctrl.reg_write = funct_ok; // bad funct writes nothing
				ctrl.reg_dst = 1'b1;
				alu_mode = 2'b10;
			end
			mips_isa_pkg::op_lw: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1; // base + offset
				ctrl.mem_to_reg = 1'b1;
			end
			mips_isa_pkg::op_sw: begin
				ctrl.alu_src = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			mips_isa_pkg::op_beq: begin
				ctrl.branch = 1'b1;
				alu_mode = 2'b01; // rs - rt, zero flag decides
			end
			mips_isa_pkg::op_addi: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
			end
			mips_isa_pkg::op_j: ctrl.jump = 1'b1;
			default: ; // unknown opcode, no-op
		endcase
	end

	//////////////////////////////////////////////////
	// alu decoder

	always_comb begin
		funct_ok = 1'b1;
		case (alu_mode)
			2'b00: ctrl.alu_op = mips_isa_pkg::alu_add; // lw sw addi
			2'b01: ctrl.alu_op = mips_isa_pkg::alu_sub; // beq
			default: begin
				case (ctrl.funct)
					mips_isa_pkg::f_add: ctrl.alu_op = mips_isa_pkg::alu_add;
					mips_isa_pkg::f_sub: ctrl.alu_op = mips_isa_pkg::alu_sub;
					mips_isa_pkg::f_and: ctrl.alu_op = mips_isa_pkg::alu_and;
					mips_isa_pkg::f_or: ctrl.alu_op = mips_isa_pkg::alu_or;
					mips_isa_pkg::f_slt: ctrl.alu_op = mips_isa_pkg::alu_slt;
					default: begin
						ctrl.alu_op = mips_isa_pkg::alu_add;
						funct_ok = 1'b0;
					end
				endcase
			end
		endcase
	end

endmodule

//--- rtl/mips_if.sv
`timescale 1ns/10ps
`include "mips_settings.svh"

// decoder <-> datapath
interface core_ctrl_if;
	logic reg_write; // rf write enable
	logic reg_dst; // 1 = rd, 0 = rt
	logic alu_src; // 1 = sign imm
	logic branch;
	logic mem_write;
	logic mem_to_reg; // wb from dmem
	logic jump;
	mips_isa_pkg::alu_op_e alu_op;
	mips_isa_pkg::opcode_e opcode; // back from instr
	mips_isa_pkg::funct_e funct;

	modport control (
		output reg_write, reg_dst, alu_src, branch, mem_write, mem_to_reg, jump, alu_op,
		input opcode, funct
	);
	modport datapath (
		input reg_write, reg_dst, alu_src, branch, mem_write, mem_to_reg, jump, alu_op,
		output opcode, funct
	);
endinterface

// one memory port, comb read, write on rising edge
interface mem_port_if;
	logic [`MIPS_DW-1:0] addr; // byte address
	logic [`MIPS_DW-1:0] wdata;
	logic we;
	logic [`MIPS_DW-1:0] rdata;

	modport initiator (output addr, wdata, we, input rdata);
	modport target (input addr, wdata, we, output rdata);
endinterface

//--- rtl/mips_host_pkg.sv
package mips_host_pkg;

	// apb word offsets
	typedef enum logic [7:0] {
		reg_steps     = 8'h00, // wo, starts a run
		reg_status    = 8'h04, // bit 0 busy
		reg_pc        = 8'h08,
		reg_imem_addr = 8'h0c,
		reg_imem_data = 8'h10, // wo, auto increment
		reg_dmem_addr = 8'h14,
		reg_dmem_data = 8'h18  // ro
	} reg_addr_e;

	// run fsm
	typedef enum logic {
		idle    = 1'b0,
		running = 1'b1
	} run_state_e;

endpackage

//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

	//////////////////////////////////////////////////
	// instruction fields

	// opcode, instr[31:26]
	typedef enum logic [5:0] {
		r_type  = 6'h00, // funct selects the op
		op_j    = 6'h02,
		op_beq  = 6'h04,
		op_addi = 6'h08,
		op_lw   = 6'h23,
		op_sw   = 6'h2b
	} opcode_e;

	// funct, instr[5:0], r-type only
	typedef enum logic [5:0] {
		f_add = 6'h20,
		f_sub = 6'h22,
		f_and = 6'h24,
		f_or  = 6'h25,
		f_slt = 6'h2a
	} funct_e;

	//////////////////////////////////////////////////
	// alu control

	// classic 3-bit alu control encoding
	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_sub = 3'b110, // also the beq compare
		alu_slt = 3'b111
	} alu_op_e;

endpackage

//--- rtl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// data and address width
`define MIPS_DW 32

// memory depths in words
`define MIPS_IMEM_WORDS 256
`define MIPS_DMEM_WORDS 256

`define MIPS_STEP_W 16 // step counter width

`endif
